// ==== source/streamer_defs.svh ====
// ------------------------------
// memory source streamer defines
// widths, fifo depths and the
// beat counter width
// ------------------------------

`ifndef STREAMER_DEFS_SVH
`define STREAMER_DEFS_SVH

`define STREAM_DW 32              // output stream word
`define MEM_DW    (`STREAM_DW + 32) // one spare bank for misaligned reads

`define ADDR_W 32 // byte address
`define LEN_W  16 // per-dimension length
`define CNT_W  32 // holds len0 * len1

`define ADDR_FIFO_DEPTH 2
// must cover every read in flight between gnt and rvalid
`define OFS_FIFO_DEPTH  8

`endif

// ==== source/streamer_pkg.sv ====
// ------------------------------
// streamer_pkg
// shared types of the memory
// source streamer
// ------------------------------

`include "streamer_defs.svh"

package streamer_pkg;

  typedef logic [`ADDR_W-1:0]    addr_t;        // byte address
  typedef logic [`LEN_W-1:0]     len_t;         // dimension length
  typedef logic [1:0]            byte_ofs_t;    // byte within a 32-bit bank
  typedef logic [`STREAM_DW-1:0] stream_word_t;
  typedef logic [`MEM_DW-1:0]    mem_word_t;

  // two-dimensional walk: base + i*stride0 + j*stride1
  typedef struct packed {
    addr_t base;
    addr_t stride0;
    len_t  len0;    // inner count
    addr_t stride1;
    len_t  len1;    // outer count
  } pattern_t;

  typedef enum logic [1:0] {
    IDLE    = 2'd0, // waiting for start
    WORKING = 2'd1, // addresses still being generated
    DONE    = 2'd2  // draining the last beats
  } state_e;

endpackage

// ==== source/mem_port_if.sv ====
// ------------------------------
// mem_port_if
// request/grant read port with a
// valid/ready response
// ------------------------------

`timescale 1ns/1ps

interface mem_port_if;

  logic                    req;
  streamer_pkg::addr_t     addr;   // full byte address, low bits masked at the pins
  logic                    gnt;
  logic                    rvalid;
  streamer_pkg::mem_word_t rdata;
  logic                    rready;

  // request side, the controller
  modport issuer (
    output req,
    output addr,
    input  gnt
  );

  // response side, tracks offsets of granted requests
  modport observer (
    input  req,
    input  addr,
    input  gnt,
    input  rvalid,
    input  rdata,
    output rready
  );

  // memory end, toward the top-level pins
  modport memory (
    input  req,
    input  addr,
    input  rready,
    output gnt,
    output rvalid,
    output rdata
  );

endinterface

// ==== source/addr_gen.sv ====
// ------------------------------
// addr_gen
// walks a 2-d byte address pattern
// one address at a time, stalls
// under back-pressure
// ------------------------------

`timescale 1ns/1ps

module addr_gen (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  logic                   start_i,
  input  streamer_pkg::pattern_t pattern_i,
  output logic                   addr_valid_o,
  input  logic                   addr_ready_i,
  output streamer_pkg::addr_t    addr_o,
  output logic                   gen_done_o
);

  streamer_pkg::addr_t stride0_q;
  streamer_pkg::addr_t stride1_q;
  streamer_pkg::len_t  len0_q;
  streamer_pkg::len_t  len1_q;
  streamer_pkg::len_t  i_q;    // inner index
  streamer_pkg::len_t  j_q;    // outer index
  streamer_pkg::addr_t addr_q; // base + i*stride0 + j*stride1
  streamer_pkg::addr_t row_q;  // base + j*stride1
  logic                valid_q;
  logic                done_q;
  logic                xfer;
  logic                last_i;
  logic                last_j;

  assign xfer   = valid_q & addr_ready_i;
  assign last_i = (i_q == len0_q - 1'b1);
  assign last_j = (j_q == len1_q - 1'b1);

  // pattern and running sums
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      stride0_q <= pattern_i.stride0;
      stride1_q <= pattern_i.stride1;
      len0_q    <= pattern_i.len0;
      len1_q    <= pattern_i.len1;
      addr_q    <= pattern_i.base;
      row_q     <= pattern_i.base;
    end else if (xfer) begin
      if (last_i) begin
        row_q  <= row_q + stride1_q; // next row
        addr_q <= row_q + stride1_q;
      end else begin
        addr_q <= addr_q + stride0_q;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      done_q  <= 1'b0;
      i_q     <= '0;
      j_q     <= '0;
    end else if (clear_i) begin
      valid_q <= 1'b0;
      done_q  <= 1'b0;
      i_q     <= '0;
      j_q     <= '0;
    end else begin
      done_q <= 1'b0; // single-cycle pulse
      if (start_i) begin
        valid_q <= 1'b1; // first address next cycle
        i_q     <= '0;
        j_q     <= '0;
      end else if (xfer) begin
        if (last_i) begin
          i_q <= '0;
          if (last_j) begin
            valid_q <= 1'b0; // final address taken
            done_q  <= 1'b1;
          end else begin
            j_q <= j_q + 1'b1;
          end
        end else begin
          i_q <= i_q + 1'b1;
        end
      end
    end
  end

  assign addr_valid_o = valid_q;
  assign addr_o       = addr_q;
  assign gen_done_o   = done_q;

endmodule

// ==== source/stream_fifo.sv ====
// ------------------------------
// stream_fifo
// valid/ready circular buffer of
// any payload type
// ------------------------------

`timescale 1ns/1ps

module stream_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 2
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     clear_i,
  input  logic     push_valid_i,
  output logic     push_ready_o,
  input  payload_t push_data_i,
  output logic     pop_valid_o,
  input  logic     pop_ready_i,
  output payload_t pop_data_o,
  output logic     empty_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  assign push_ready_o = (count_q != CNT_W'(DEPTH)); // drops when full
  assign pop_valid_o  = (count_q != '0);
  assign empty_o      = (count_q == '0);
  assign pop_data_o   = mem_q[rd_ptr_q];
  assign push         = push_valid_i & push_ready_o;
  assign pop          = pop_valid_o & pop_ready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0; // flush
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // a push refused while full is held until the buffer has room
  a_push_held_full: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    push_valid_i && !push_ready_o |=> push_valid_i);

  a_count_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    count_q <= CNT_W'(DEPTH));

endmodule

// ==== source/realign_buffer.sv ====
// ------------------------------
// realign_buffer
// tracks byte offsets of granted
// reads, holds the response and
// realigns it into the stream
// ------------------------------

`timescale 1ns/1ps

`include "streamer_defs.svh"

module realign_buffer (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       clear_i,
  mem_port_if.observer               mem,
  output logic                       stream_valid_o,
  input  logic                       stream_ready_i,
  output streamer_pkg::stream_word_t stream_data_o,
  output logic                       beat_o
);

  logic                    ofs_push;
  logic                    ofs_push_ready;
  logic                    ofs_valid;
  streamer_pkg::byte_ofs_t ofs;         // offset of the beat at the head
  logic                    hold_valid_q;
  streamer_pkg::mem_word_t hold_data_q;
  streamer_pkg::mem_word_t word;
  streamer_pkg::mem_word_t shifted;

  assign ofs_push = mem.req & mem.gnt; // one entry per accepted read

  stream_fifo #(
    .payload_t ( streamer_pkg::byte_ofs_t ),
    .DEPTH     ( `OFS_FIFO_DEPTH          )
  ) u_ofs_fifo (
    .clk_i        ( clk_i          ),
    .rst_ni       ( rst_ni         ),
    .clear_i      ( clear_i        ),
    .push_valid_i ( ofs_push       ),
    .push_ready_o ( ofs_push_ready ),
    .push_data_i  ( mem.addr[1:0]  ),
    .pop_valid_o  ( ofs_valid      ),
    .pop_ready_i  ( beat_o         ),
    .pop_data_o   ( ofs            ),
    .empty_o      (                )
  );

  assign mem.rready     = stream_ready_i; // stall the memory with the stream
  assign stream_valid_o = mem.rvalid | hold_valid_q;
  assign beat_o         = stream_valid_o & stream_ready_i;

  // the held word wins so the stream data stays put while waiting
  assign word          = hold_valid_q ? hold_data_q : mem.rdata;
  assign shifted       = word >> {ofs, 3'b000};
  assign stream_data_o = shifted[`STREAM_DW-1:0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_valid_q <= 1'b0;
    end else if (clear_i) begin
      hold_valid_q <= 1'b0;
    end else if (beat_o) begin
      hold_valid_q <= 1'b0; // taken
    end else if (mem.rvalid) begin
      hold_valid_q <= 1'b1; // stalled beat
    end
  end

  always_ff @(posedge clk_i) begin
    if (mem.rvalid && !hold_valid_q) begin
      hold_data_q <= mem.rdata;
    end
  end

  // offset fifo must be deep enough for the memory latency
  a_ofs_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ofs_push |-> ofs_push_ready);

  a_rvalid_has_ofs: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem.rvalid |-> ofs_valid);

endmodule

// ==== source/source_ctrl.sv ====
// ------------------------------
// source_ctrl
// idle/working/done sequencing,
// read request issue and beat
// counting
// ------------------------------

`timescale 1ns/1ps

`include "streamer_defs.svh"

module source_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  logic                   start_i,
  input  streamer_pkg::pattern_t pattern_i,
  input  logic                   gen_done_i,
  input  logic                   fifo_valid_i,
  output logic                   fifo_ready_o,
  input  streamer_pkg::addr_t    fifo_addr_i,
  input  logic                   fifo_empty_i,
  input  logic                   stream_ready_i,
  input  logic                   beat_i,
  mem_port_if.issuer             mem,
  output logic                   ready_start_o,
  output logic                   done_o
);

  streamer_pkg::state_e state_q;
  streamer_pkg::state_e state_d;
  logic                 done_q;
  logic                 done_d;
  logic                 start_ok;
  logic [`CNT_W-1:0]    total_q; // len0 * len1
  logic [`CNT_W-1:0]    cnt_q;   // delivered beats

  assign start_ok = start_i & (state_q == streamer_pkg::IDLE);

  always_comb begin
    state_d = state_q;
    done_d  = 1'b0;
    case (state_q)
      streamer_pkg::IDLE:    if (start_i) state_d = streamer_pkg::WORKING;
      streamer_pkg::WORKING: if (gen_done_i) state_d = streamer_pkg::DONE;
      streamer_pkg::DONE: begin
        if (done_q) begin
          state_d = streamer_pkg::IDLE; // leave with the pulse
        end else if (fifo_empty_i && (cnt_q == total_q)) begin
          done_d = 1'b1;
        end
      end
      default: state_d = streamer_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= streamer_pkg::IDLE;
      done_q  <= 1'b0;
      cnt_q   <= '0;
    end else if (clear_i) begin
      state_q <= streamer_pkg::IDLE;
      done_q  <= 1'b0;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      done_q  <= done_d;
      if (start_ok) begin
        cnt_q <= '0;
      end else if (beat_i) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_ok) begin
      total_q <= `CNT_W'(pattern_i.len0) * `CNT_W'(pattern_i.len1);
    end
  end

  // issue only when the stream can take the result
  assign mem.req      = (state_q != streamer_pkg::IDLE) & fifo_valid_i & stream_ready_i;
  assign mem.addr     = fifo_addr_i;
  assign fifo_ready_o = mem.req & mem.gnt; // pop on grant

  assign ready_start_o = (state_q == streamer_pkg::IDLE);
  assign done_o        = done_q;

  // no stream beat arrives outside a job
  a_no_beat_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == streamer_pkg::IDLE) |-> !beat_i);

  // done is a single pulse and is followed by ready_start
  a_done_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_o |=> !done_o && ready_start_o);

endmodule

// ==== source/mem_source_top.sv ====
// ------------------------------
// mem_source_top
// memory source streamer, 2-d
// read pattern to a 32-bit stream
// ------------------------------

`timescale 1ns/1ps

`include "streamer_defs.svh"

module mem_source_top (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       clear_i,
  input  logic                       start_i,
  input  streamer_pkg::addr_t        base_i,
  input  streamer_pkg::addr_t        stride0_i,
  input  streamer_pkg::len_t         len0_i,
  input  streamer_pkg::addr_t        stride1_i,
  input  streamer_pkg::len_t         len1_i,
  output logic                       ready_start_o,
  output logic                       done_o,
  output logic                       mem_req_o,
  output streamer_pkg::addr_t        mem_addr_o,
  input  logic                       mem_gnt_i,
  input  logic                       mem_rvalid_i,
  input  streamer_pkg::mem_word_t    mem_rdata_i,
  output logic                       mem_rready_o,
  output logic                       stream_valid_o,
  input  logic                       stream_ready_i,
  output streamer_pkg::stream_word_t stream_data_o
);

  streamer_pkg::pattern_t pattern;
  logic                   gen_start;  // start seen by the generator
  logic                   gen_valid;
  logic                   gen_ready;
  streamer_pkg::addr_t    gen_addr;
  logic                   gen_done;
  logic                   fifo_valid;
  logic                   fifo_ready;
  streamer_pkg::addr_t    fifo_addr;
  logic                   fifo_empty;
  logic                   beat;

  mem_port_if u_mem_port ();

  assign pattern = '{
    base:    base_i,
    stride0: stride0_i,
    len0:    len0_i,
    stride1: stride1_i,
    len1:    len1_i
  };

  assign gen_start = start_i & ready_start_o;

  // memory pins carry the word address with the byte offset cleared
  assign mem_req_o          = u_mem_port.req;
  assign mem_addr_o         = {u_mem_port.addr[`ADDR_W-1:2], 2'b00};
  assign u_mem_port.gnt     = mem_gnt_i;
  assign u_mem_port.rvalid  = mem_rvalid_i;
  assign u_mem_port.rdata   = mem_rdata_i;
  assign mem_rready_o       = u_mem_port.rready;

  addr_gen u_addr_gen (
    .clk_i        ( clk_i     ),
    .rst_ni       ( rst_ni    ),
    .clear_i      ( clear_i   ),
    .start_i      ( gen_start ),
    .pattern_i    ( pattern   ),
    .addr_valid_o ( gen_valid ),
    .addr_ready_i ( gen_ready ),
    .addr_o       ( gen_addr  ),
    .gen_done_o   ( gen_done  )
  );

  stream_fifo #(
    .payload_t ( streamer_pkg::addr_t ),
    .DEPTH     ( `ADDR_FIFO_DEPTH     )
  ) u_addr_fifo (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .clear_i      ( clear_i    ),
    .push_valid_i ( gen_valid  ),
    .push_ready_o ( gen_ready  ),
    .push_data_i  ( gen_addr   ),
    .pop_valid_o  ( fifo_valid ),
    .pop_ready_i  ( fifo_ready ),
    .pop_data_o   ( fifo_addr  ),
    .empty_o      ( fifo_empty )
  );

  source_ctrl u_source_ctrl (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .clear_i        ( clear_i        ),
    .start_i        ( start_i        ),
    .pattern_i      ( pattern        ),
    .gen_done_i     ( gen_done       ),
    .fifo_valid_i   ( fifo_valid     ),
    .fifo_ready_o   ( fifo_ready     ),
    .fifo_addr_i    ( fifo_addr      ),
    .fifo_empty_i   ( fifo_empty     ),
    .stream_ready_i ( stream_ready_i ),
    .beat_i         ( beat           ),
    .mem            ( u_mem_port     ),
    .ready_start_o  ( ready_start_o  ),
    .done_o         ( done_o         )
  );

  realign_buffer u_realign_buffer (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .clear_i        ( clear_i        ),
    .mem            ( u_mem_port     ),
    .stream_valid_o ( stream_valid_o ),
    .stream_ready_i ( stream_ready_i ),
    .stream_data_o  ( stream_data_o  ),
    .beat_o         ( beat           )
  );

endmodule

// ==== bench/tb_mem_source.sv ====
// ------------------------------
// tb_mem_source
// trace-driven testbench of the
// memory source streamer with a
// random-latency memory model
// ------------------------------

`timescale 1ns/1ps

`include "streamer_defs.svh"

module tb_mem_source;

  logic                       clk_i;
  logic                       rst_ni;
  logic                       clear_i;
  logic                       start_i;
  streamer_pkg::addr_t        base_i;
  streamer_pkg::addr_t        stride0_i;
  streamer_pkg::len_t         len0_i;
  streamer_pkg::addr_t        stride1_i;
  streamer_pkg::len_t         len1_i;
  logic                       ready_start_o;
  logic                       done_o;
  logic                       mem_req_o;
  streamer_pkg::addr_t        mem_addr_o;
  logic                       mem_gnt_i;
  logic                       mem_rvalid_i;
  streamer_pkg::mem_word_t    mem_rdata_i;
  logic                       mem_rready_o;
  logic                       stream_valid_o;
  logic                       stream_ready_i;
  streamer_pkg::stream_word_t stream_data_o;

  int                         errors;
  int                         cyc;
  int                         beats;     // stream transfers in this job
  int                         done_cnt;  // done_o pulses in this job
  int                         job_total; // len0 * len1
  bit                         rand_mode; // ready gaps, grant stalls, latency
  bit                         hold_seen;
  streamer_pkg::stream_word_t held_word;
  streamer_pkg::addr_t        rd_addr_q[$]; // accepted reads, in order
  int                         rd_due_q[$];  // cycle each read may return
  streamer_pkg::stream_word_t exp_word_q[$];
  streamer_pkg::addr_t        exp_addr_q[$];

  mem_source_top u_mem_source_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic check_word(input string name, input streamer_pkg::stream_word_t got,
                            input streamer_pkg::stream_word_t exp);
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input streamer_pkg::addr_t got,
                            input streamer_pkg::addr_t exp);
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input logic [`CNT_W-1:0] got,
                             input logic [`CNT_W-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic report_error(input string what);
    errors++;
    $display("error: %s", what);
  endtask

  task automatic abort_run(input string why);
    $display("error: %s", why);
    $display("TESTBENCH FAILED");
    $finish;
  endtask

  // byte A of memory holds A[7:0] ^ 5a in little endian order within the word
  function automatic streamer_pkg::mem_word_t mem_word(input streamer_pkg::addr_t wa);
    streamer_pkg::mem_word_t w;
    streamer_pkg::addr_t     a;
    for (int k = 0; k < 8; k++) begin
      a         = wa + k;
      w[8*k+:8] = a[7:0] ^ 8'h5a;
    end
    return w;
  endfunction

  // skips comment and blank lines and returns an empty string at end of file
  task automatic next_line(input int fd, output string line);
    string raw;
    int    r;
    line = "";
    while (!$feof(fd) && line.len() == 0) begin
      r = $fgets(raw, fd);
      if (r > 0 && raw.len() > 1 && raw[0] != "#") line = raw;
    end
  endtask

  // memory model and stream monitor drive on negedge and sample just before posedge
  initial begin
    void'($urandom(32'hf0e9));
    mem_gnt_i      = 1'b0;
    mem_rvalid_i   = 1'b0;
    mem_rdata_i    = '0;
    stream_ready_i = 1'b0;
    hold_seen      = 1'b0;
    forever begin
      @(negedge clk_i);
      cyc++;
      mem_gnt_i      = rst_ni && (rd_addr_q.size() < 4) &&
                       (!rand_mode || $urandom_range(3) != 0);
      mem_rvalid_i   = rst_ni && (rd_addr_q.size() > 0) && (rd_due_q[0] <= cyc);
      mem_rdata_i    = mem_rvalid_i ? mem_word(rd_addr_q[0]) : '0;
      stream_ready_i = rst_ni && (!rand_mode || $urandom_range(2) != 0);
      #4;
      if (mem_req_o && mem_gnt_i) begin
        if (exp_addr_q.size() == 0) report_error("read request beyond the pattern");
        else check_addr("mem_addr_o", mem_addr_o, exp_addr_q.pop_front());
        rd_addr_q.push_back(mem_addr_o);
        rd_due_q.push_back(cyc + (rand_mode ? $urandom_range(4, 1) : 1));
      end
      if (mem_rvalid_i && mem_rready_o) begin
        void'(rd_addr_q.pop_front());
        void'(rd_due_q.pop_front());
      end
      if (hold_seen && !stream_valid_o) report_error("stream_valid_o dropped before transfer");
      if (hold_seen && stream_valid_o) check_word("stream_data_o held", stream_data_o, held_word);
      hold_seen = stream_valid_o && !stream_ready_i;
      held_word = stream_data_o;
      if (stream_valid_o && stream_ready_i) begin
        beats++;
        if (exp_word_q.size() == 0) report_error("extra stream word");
        else check_word("stream_data_o", stream_data_o, exp_word_q.pop_front());
      end
      if (done_o) begin
        done_cnt++;
        if (beats != job_total) report_error("done_o came before the last beat");
      end
    end
  end

  initial begin
    int                         fd;
    int                         r;
    int                         rnd;
    int                         job_no;
    int                         fails;
    int                         job_err;
    int                         wait_cyc;
    string                      line;
    streamer_pkg::addr_t        base;
    streamer_pkg::addr_t        s0;
    streamer_pkg::addr_t        s1;
    streamer_pkg::len_t         l0;
    streamer_pkg::len_t         l1;
    streamer_pkg::stream_word_t w;
    {rst_ni, clear_i, start_i} = 3'b000;
    {base_i, stride0_i, stride1_i, len0_i, len1_i} = '0;
    {errors, cyc, beats, done_cnt, job_total, job_no, fails} = '0;
    rand_mode = 1'b0;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    fd = $fopen("bench/source_trace.txt", "r");
    if (fd == 0) abort_run("cannot open the trace file");
    next_line(fd, line);
    while (line.len() > 0) begin
      r = $sscanf(line, "job %h %h %h %h %h %h", base, s0, l0, s1, l1, rnd);
      if (r != 6) abort_run("bad job line in the trace file");
      job_total = l0 * l1;
      exp_word_q.delete();
      exp_addr_q.delete();
      for (int n = 0; n < job_total; n++) begin
        next_line(fd, line);
        if ($sscanf(line, "exp %h", w) != 1) abort_run("missing expected word in trace");
        exp_word_q.push_back(w);
      end
      for (int j = 0; j < l1; j++) begin
        for (int i = 0; i < l0; i++) begin
          exp_addr_q.push_back((base + i * s0 + j * s1) & ~32'h3); // word address
        end
      end
      job_err   = errors;
      beats     = 0;
      done_cnt  = 0;
      rand_mode = (rnd != 0);
      wait_cyc  = 0;
      @(negedge clk_i);
      while (!ready_start_o) begin
        wait_cyc++;
        if (wait_cyc > 100) abort_run("timeout waiting for ready_start_o");
        @(negedge clk_i);
      end
      {base_i, stride0_i, len0_i, stride1_i, len1_i} = {base, s0, l0, s1, l1};
      start_i = 1'b1;
      @(negedge clk_i);
      start_i  = 1'b0;
      wait_cyc = 0;
      while (done_cnt == 0) begin
        @(posedge clk_i);
        wait_cyc++;
        if (wait_cyc > 2000) abort_run("timeout waiting for done_o");
      end
      @(negedge clk_i);
      if (!ready_start_o) report_error("ready_start_o low after done_o");
      repeat (3) @(posedge clk_i);
      check_count("beats", beats, job_total);
      check_count("done_o pulses", done_cnt, 1);
      if (exp_word_q.size() != 0 || exp_addr_q.size() != 0) report_error("words not delivered");
      job_no++;
      if (errors == job_err) begin
        $display("job %0d passed, %0d beats", job_no, beats);
      end else begin
        fails++;
        $display("job %0d failed, %0d errors", job_no, errors - job_err);
      end
      next_line(fd, line);
    end
    $fclose(fd);
    $display("jobs %0d, failed %0d, errors %0d", job_no, fails, errors);
    if (errors == 0 && job_no > 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== bench/source_trace.txt ====
# job: base stride0 len0 stride1 len1 random (hex), then len0*len1 lines
# exp: expected stream word (hex), in stream order
# aligned 1-d job
job 00000100 00000004 0004 00000000 0001 0
exp 59585b5a
exp 5d5c5f5e
exp 51505352
exp 55545756
# misaligned base, offsets 1 2 3
job 00000201 00000001 0003 00000000 0001 0
exp 5e59585b
exp 5f5e5958
exp 5c5f5e59
# 2-d pattern
job 00000300 00000008 0002 00000020 0003 0
exp 59585b5a
exp 51505352
exp 79787b7a
exp 71707372
exp 19181b1a
exp 11101312
# 2-d misaligned with ready gaps and random latency
job 000000fe 00000005 0003 00000040 0002 1
exp 5b5aa5a4
exp 5c5f5e59
exp 51505352
exp 1b1a6564
exp 1c1f1e19
exp 11101312
# second job after completion, random timing
job 00000400 00000004 0003 00000000 0001 1
exp 59585b5a
exp 5d5c5f5e
exp 51505352

// ==== flist.f ====
+incdir+source
source/streamer_pkg.sv
source/mem_port_if.sv
source/addr_gen.sv
source/stream_fifo.sv
source/realign_buffer.sv
source/source_ctrl.sv
source/mem_source_top.sv
bench/tb_mem_source.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the streamer testbench with Verilator

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_mem_source -f flist.f -o tb_mem_source > build.log 2>&1 &&
./obj_dir/tb_mem_source > sim.log 2>&1 ||
{ echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "TESTBENCH FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
echo "simulation passed"
exit 0
